// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = soc_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_tb import soc_pkg::*; ();

	localparam int    NUM_TESTS   = 6;
	localparam int    PROG_LEN    = 12;
	localparam int    WATCHDOG_NS = NUM_TESTS * PROG_LEN * 10 * 40;
	localparam word_t EBREAK      = 32'h0010_0073;
	localparam int    STORE_UP    = 32'h87654; // Word stored by the load tests
	localparam int    STORE_LO    = 32'h321;
	localparam int    STORE_BYTE  = 32'h0f0;   // Replaces byte 1 of that word

	logic       clock;
	logic       rst_n;
	logic       start;
	boot_wr_t   boot;
	addr_t      pc;
	logic       retire;
	logic       halted;
	logic       fault;
	word_t      halt_ret;
	logic       tx_valid;
	logic [7:0] tx_data;

	string      test_name [NUM_TESTS];
	word_t      prog [NUM_TESTS][PROG_LEN];
	word_t      exp_ret [NUM_TESTS];
	logic       exp_fault [NUM_TESTS];
	int         exp_retire [NUM_TESTS];
	int         exp_tx_cnt [NUM_TESTS];
	logic [7:0] exp_tx [NUM_TESTS][4];
	logic [7:0] tx_q [$];
	int         retire_cnt;
	int         cur;
	int         fill;
	int         errs;
	int         pass_cnt;
	int         fail_cnt;
	int         seed;

	soc_top DUT (
		.clock, .rst_n, .start, .boot,
		.pc, .retire, .halted, .fault, .halt_ret, .tx_valid, .tx_data
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	always @(posedge clock) begin
		if (tx_valid)
			tx_q.push_back(tx_data);
		if (retire)
			retire_cnt++;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the core did not halt in time");
		$display("STATUS: FAIL");
		$finish;
	end

	// RV32I instruction formats
	function automatic word_t itype(input logic [6:0] op, input int rd, input int f3,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t rtype(input logic sub, input int rd, input int f3,
		input int rs1, input int rs2);
		return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
	endfunction

	function automatic word_t stype(input int f3, input int rs1, input int rs2, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
	endfunction

	function automatic word_t btype(input int f3, input int rs1, input int rs2, input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t utype(input int rd, input int up);
		return {up[19:0], rd[4:0], OP_LUI};
	endfunction

	function automatic word_t jtype(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
	endfunction

	function automatic word_t sext12(input int v);
		return {{20{v[11]}}, v[11:0]};
	endfunction

	function automatic word_t sext8(input logic [7:0] b);
		return {{24{b[7]}}, b};
	endfunction

	function automatic word_t sext16(input logic [15:0] h);
		return {{16{h[15]}}, h};
	endfunction

	task automatic new_test(input int t, input string name);
		cur           = t;
		fill          = 0;
		test_name[t]  = name;
		exp_fault[t]  = 1'b0;
		exp_tx_cnt[t] = 0;
		for (int k = 0; k < PROG_LEN; k++)
			prog[t][k] = EBREAK; // Unused slots halt
		for (int k = 0; k < 4; k++)
			exp_tx[t][k] = 8'h00;
	endtask

	task automatic emit(input word_t w);
		prog[cur][fill] = w;
		fill++;
	endtask

	task automatic emit_store_prefix();
		emit(utype(5, SRAM_BASE >> 12));
		emit(utype(6, STORE_UP));
		emit(itype(OP_IMM, 6, 0, 6, STORE_LO));
		emit(stype(2, 5, 6, 32'h200));           // sw of x6 at 0x200(x5)
		emit(itype(OP_IMM, 7, 0, 0, STORE_BYTE));
		emit(stype(0, 5, 7, 32'h201));           // sb into byte 1
	endtask

	task automatic build_table();
		int    ru;
		int    ri1;
		int    ri2;
		word_t v5;
		word_t v6;
		word_t v7;
		word_t v10;
		word_t data_w;
		word_t tmp;

		ru  = $random(seed);
		ri1 = $random(seed);
		ri2 = $random(seed);
		new_test(0, "arith");
		emit(utype(5, ru));
		emit(itype(OP_IMM, 5, 0, 5, ri1));
		emit(itype(OP_IMM, 6, 0, 0, ri2));
		emit(rtype(1'b0, 7, 0, 5, 6));
		emit(rtype(1'b1, 11, 0, 5, 6));          // sub
		emit(rtype(1'b0, 12, 4, 7, 11));         // xor
		emit(rtype(1'b0, 10, 6, 12, 6));         // or
		emit(rtype(1'b0, 11, 7, 5, 7));          // and
		emit(rtype(1'b0, 10, 4, 10, 11));
		v5  = {ru[19:0], 12'b0} + sext12(ri1);
		v6  = sext12(ri2);
		v7  = v5 + v6;
		v10 = (v7 ^ (v5 - v6)) | v6;
		exp_ret[0]    = v10 ^ (v5 & v7);
		exp_retire[0] = fill + 1;                // Straight line plus ebreak

		data_w = {STORE_UP[19:0], 12'b0} + sext12(STORE_LO);
		tmp    = sext12(STORE_BYTE);
		data_w[15:8] = tmp[7:0];
		new_test(1, "ld_signed");
		emit_store_prefix();
		emit(itype(OP_LOAD, 10, 0, 5, 32'h201)); // lb
		emit(itype(OP_LOAD, 11, 1, 5, 32'h202)); // lh
		emit(rtype(1'b0, 10, 0, 10, 11));
		emit(itype(OP_LOAD, 12, 2, 5, 32'h200)); // lw
		emit(rtype(1'b0, 10, 4, 10, 12));
		exp_ret[1]    = (sext8(data_w[15:8]) + sext16(data_w[31:16])) ^ data_w;
		exp_retire[1] = fill + 1;

		new_test(2, "ld_unsigned");
		emit_store_prefix();
		emit(itype(OP_LOAD, 10, 4, 5, 32'h201)); // lbu
		emit(itype(OP_LOAD, 11, 5, 5, 32'h202)); // lhu
		emit(rtype(1'b0, 10, 0, 10, 11));
		emit(itype(OP_LOAD, 12, 5, 5, 32'h200));
		emit(rtype(1'b0, 10, 4, 10, 12));
		exp_ret[2] = ({24'b0, data_w[15:8]} + {16'b0, data_w[31:16]}) ^ {16'b0, data_w[15:0]};
		exp_retire[2] = fill + 1;

		new_test(3, "branch");
		emit(itype(OP_IMM, 10, 0, 0, 1));
		emit(itype(OP_IMM, 5, 0, 0, 5));
		emit(btype(0, 5, 0, 8));                 // beq not taken
		emit(btype(1, 5, 0, 8));                 // bne taken
		emit(itype(OP_IMM, 10, 0, 10, 100));
		emit(btype(0, 5, 5, 8));                 // beq taken
		emit(itype(OP_IMM, 10, 0, 10, 200));
		emit(btype(1, 5, 5, 8));                 // bne not taken
		emit(jtype(11, 8));                      // jal at word 8
		emit(itype(OP_IMM, 10, 0, 10, 400));
		emit(rtype(1'b0, 10, 0, 10, 11));
		exp_ret[3]    = 32'd1 + (RESET_PC + 32'd32 + 32'd4);
		exp_retire[3] = 9;                       // Eight executed plus ebreak

		new_test(4, "uart");
		emit(itype(OP_IMM, 10, 0, 0, 7));
		emit(utype(5, UART_ADDR >> 12));
		emit(itype(OP_IMM, 6, 0, 0, 32'h48));
		emit(stype(0, 5, 6, 0));                 // sb
		emit(itype(OP_IMM, 6, 0, 0, 32'h169));
		emit(stype(2, 5, 6, 0));                 // sw
		emit(utype(7, 32'h12345));
		emit(itype(OP_IMM, 7, 0, 7, 32'hfa5));
		emit(stype(0, 5, 7, 0));
		emit(itype(OP_LOAD, 10, 2, 5, 0));       // Read of the transmit register
		exp_ret[4]    = 32'd0;
		exp_retire[4] = fill + 1;
		exp_tx_cnt[4] = 3;
		tmp           = sext12(32'h48);
		exp_tx[4][0]  = tmp[7:0];
		tmp           = sext12(32'h169);
		exp_tx[4][1]  = tmp[7:0];
		tmp           = 32'h1234_5000 + sext12(32'hfa5);
		exp_tx[4][2]  = tmp[7:0];

		new_test(5, "unmapped");
		emit(itype(OP_IMM, 10, 0, 0, 32'h55));
		emit(utype(5, 32'h20000));
		emit(itype(OP_LOAD, 6, 2, 5, 0));
		emit(itype(OP_IMM, 10, 0, 0, 1));        // Must not execute
		exp_ret[5]    = 32'h55;
		exp_fault[5]  = 1'b1;
		exp_retire[5] = 2;                       // Faulting load does not retire
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		assert (act === exp) else begin
			$display("ERR %s %s: expected %08h, actual %08h", test_name[cur], what, exp, act);
			errs++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("ERR %s %s: expected %b, actual %b", test_name[cur], what, exp, act);
			errs++;
		end
	endtask

	task automatic check_idle();
		check_bit("halted before start", 1'b0, halted);
		check_bit("retire before start", 1'b0, retire);
		check_bit("fault before start", 1'b0, fault);
		check_bit("tx_valid before start", 1'b0, tx_valid);
		check_word("pc before start", RESET_PC, pc);
	endtask

	task automatic reset_dut();
		@(posedge clock);
		rst_n <= 1'b0;
		start <= 1'b0;
		boot  <= '0;
		repeat (10) begin
			@(posedge clock);
			check_idle();
		end
		rst_n <= 1'b1;
	endtask

	task automatic load_program();
		for (int k = 0; k < PROG_LEN; k++) begin
			@(posedge clock);
			boot <= '{en: 1'b1, idx: sram_idx_t'(k), data: prog[cur][k]};
			check_idle();
		end
		@(posedge clock);
		boot <= '0;
		check_idle();
	endtask

	task automatic run_test(input int t);
		int tx_base;
		int tx_cnt;
		int retire_base;

		cur  = t;
		errs = 0;
		reset_dut();
		tx_base     = tx_q.size();
		retire_base = retire_cnt;
		load_program();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		while (halted !== 1'b1)
			@(posedge clock);
		repeat (2) @(posedge clock);
		tx_cnt = tx_q.size() - tx_base;
		check_word("a0", exp_ret[t], halt_ret);
		check_bit("fault", exp_fault[t], fault);
		check_word("retire count", word_t'(exp_retire[t]), word_t'(retire_cnt - retire_base));
		check_word("tx count", word_t'(exp_tx_cnt[t]), word_t'(tx_cnt));
		for (int k = 0; k < exp_tx_cnt[t] && k < tx_cnt; k++)
			check_word($sformatf("tx byte %0d", k), {24'b0, exp_tx[t][k]},
				{24'b0, tx_q[tx_base + k]});
		if (errs == 0) begin
			pass_cnt++;
			$display("Test %s: ok", test_name[t]);
		end else begin
			fail_cnt++;
			$display("Test %s: %0d check(s) wrong", test_name[t], errs);
		end
	endtask

	initial begin
		rst_n      <= 1'b0;
		start      <= 1'b0;
		boot       <= '0;
		seed       = 32'hf870_7253;
		retire_cnt = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		build_table();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/soc_pkg.sv
source/rv_decode.sv
source/rv_core.sv
source/bus_xbar.sv
source/sram_slave.sv
source/uart_tx_slave.sv
source/soc_top.sv
bench/soc_tb.sv

// ==== source/bus_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_xbar import soc_pkg::*; (
	input  wire           clock,
	input  wire           rst_n,
	input  wire bus_req_t ifu_req,
	input  wire           ifu_req_valid,
	output logic          ifu_req_ready,
	output bus_rsp_t      ifu_rsp,
	output logic          ifu_rsp_valid,
	input  wire bus_req_t lsu_req,
	input  wire           lsu_req_valid,
	output logic          lsu_req_ready,
	output bus_rsp_t      lsu_rsp,
	output logic          lsu_rsp_valid,
	output bus_req_t      sram_req,
	output logic          sram_req_valid,
	input  wire           sram_req_ready,
	input  wire bus_rsp_t sram_rsp,
	input  wire           sram_rsp_valid,
	output bus_req_t      uart_req,
	output logic          uart_req_valid,
	input  wire           uart_req_ready,
	input  wire bus_rsp_t uart_rsp,
	input  wire           uart_rsp_valid
);

	bus_req_t req_sel;
	logic     any_valid, hit_sram, hit_uart, slave_ready, accept;
	logic     busy, grant_lsu, tgt_sram, tgt_uart;
	bus_rsp_t rsp_sel;
	logic     rsp_valid_sel;

	assign req_sel   = lsu_req_valid ? lsu_req : ifu_req; // lsu has priority
	assign any_valid = lsu_req_valid | ifu_req_valid;

	assign hit_sram = (req_sel.addr >= SRAM_BASE)
		&& (req_sel.addr < SRAM_BASE + addr_t'(SRAM_WORDS * 4));
	assign hit_uart = (req_sel.addr[31:2] == UART_ADDR[31:2]);

	assign slave_ready = hit_sram ? sram_req_ready : (hit_uart ? uart_req_ready : 1'b1);
	assign accept      = !busy && any_valid && slave_ready;

	assign sram_req       = req_sel;
	assign uart_req       = req_sel;
	assign sram_req_valid = !busy && any_valid && hit_sram;
	assign uart_req_valid = !busy && any_valid && hit_uart;

	assign lsu_req_ready = !busy && lsu_req_valid && slave_ready;
	assign ifu_req_ready = !busy && !lsu_req_valid && slave_ready;

	// Unmapped target answers by itself one cycle after accept
	assign rsp_sel       = tgt_sram ? sram_rsp : (tgt_uart ? uart_rsp : '{rdata: '0, err: 1'b1});
	assign rsp_valid_sel = tgt_sram ? sram_rsp_valid : (tgt_uart ? uart_rsp_valid : 1'b1);

	assign ifu_rsp       = rsp_sel;
	assign lsu_rsp       = rsp_sel;
	assign ifu_rsp_valid = busy && rsp_valid_sel && !grant_lsu;
	assign lsu_rsp_valid = busy && rsp_valid_sel && grant_lsu;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			grant_lsu <= 1'b0;
			tgt_sram  <= 1'b0;
			tgt_uart  <= 1'b0;
		end else if (accept) begin
			busy      <= 1'b1;
			grant_lsu <= lsu_req_valid;
			tgt_sram  <= hit_sram;
			tgt_uart  <= hit_uart;
		end else if (busy && rsp_valid_sel) begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import soc_pkg::*; (
	input  wire           clock,
	input  wire           rst_n,
	input  wire           start,
	output bus_req_t      ifu_req,
	output logic          ifu_req_valid,
	input  wire           ifu_req_ready,
	input  wire bus_rsp_t ifu_rsp,
	input  wire           ifu_rsp_valid,
	output bus_req_t      lsu_req,
	output logic          lsu_req_valid,
	input  wire           lsu_req_ready,
	input  wire bus_rsp_t lsu_rsp,
	input  wire           lsu_rsp_valid,
	output addr_t         pc,
	output logic          retire,
	output logic          halted,
	output logic          fault,
	output word_t         halt_ret
);

	core_state_t state;
	word_t       instr;
	word_t       rf [32];
	logic        ifu_wait;
	logic        lsu_wait;

	reg_idx_t    rs1, rs2, rd;
	word_t       imm;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        is_sub, wen_rd, is_load, is_store;
	strb_t       mem_strb;

	word_t       rs1_val, rs2_val, alu_b, alu_out;
	word_t       pc_plus4, next_pc, mem_addr, rd_shift, load_val, rf_wdata;
	logic        br_taken, rf_wen;

	rv_decode u_decode (
		.instr   (instr),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.imm     (imm),
		.opcode  (opcode),
		.funct3  (funct3),
		.is_sub  (is_sub),
		.wen_rd  (wen_rd),
		.is_load (is_load),
		.is_store(is_store),
		.mem_strb(mem_strb)
	);

	assign rs1_val  = (rs1 == '0) ? '0 : rf[rs1];
	assign rs2_val  = (rs2 == '0) ? '0 : rf[rs2];
	assign halt_ret = rf[10]; // a0
	assign pc_plus4 = pc + 32'd4;

	assign alu_b = (opcode == OP_REG) ? rs2_val : imm;

	always_comb begin
		case (funct3)
			3'b000:  alu_out = is_sub ? rs1_val - alu_b : rs1_val + alu_b;
			3'b100:  alu_out = rs1_val ^ alu_b;
			3'b110:  alu_out = rs1_val | alu_b;
			3'b111:  alu_out = rs1_val & alu_b;
			default: alu_out = rs1_val + alu_b;
		endcase
		if (opcode == OP_LUI)
			alu_out = imm;
	end

	assign br_taken = (opcode == OP_JAL)
		|| ((opcode == OP_BRANCH) && ((rs1_val == rs2_val) ^ funct3[0])); // beq / bne
	assign next_pc = br_taken ? pc + imm : pc_plus4;

	assign mem_addr = rs1_val + imm;
	assign rd_shift = lsu_rsp.rdata >> {mem_addr[1:0], 3'b000};

	always_comb begin
		case (funct3)
			3'b000:  load_val = {{24{rd_shift[7]}}, rd_shift[7:0]};
			3'b001:  load_val = {{16{rd_shift[15]}}, rd_shift[15:0]};
			3'b100:  load_val = {24'b0, rd_shift[7:0]};
			3'b101:  load_val = {16'b0, rd_shift[15:0]};
			default: load_val = lsu_rsp.rdata;
		endcase
	end

	assign ifu_req       = '{addr: pc, wdata: '0, wstrb: '0, write: 1'b0};
	assign ifu_req_valid = (state == FETCH) && !ifu_wait;

	assign lsu_req.addr  = mem_addr;
	assign lsu_req.wdata = rs2_val << {mem_addr[1:0], 3'b000};
	assign lsu_req.wstrb = is_store ? strb_t'(mem_strb << mem_addr[1:0]) : '0;
	assign lsu_req.write = is_store;
	assign lsu_req_valid = (state == MEM) && !lsu_wait;

	assign rf_wen = ((state == EXEC) && wen_rd && !is_load)
		|| ((state == MEM) && lsu_rsp_valid && !lsu_rsp.err && is_load);
	assign rf_wdata = (state == MEM) ? load_val : ((opcode == OP_JAL) ? pc_plus4 : alu_out);

	assign halted = (state == HALT);

	always_ff @(posedge clock) begin
		if (rf_wen && (rd != '0))
			rf[rd] <= rf_wdata;
		if ((state == FETCH) && ifu_rsp_valid)
			instr <= ifu_rsp.rdata;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			pc       <= RESET_PC;
			retire   <= 1'b0;
			fault    <= 1'b0;
			ifu_wait <= 1'b0;
			lsu_wait <= 1'b0;
		end else begin
			retire <= 1'b0;
			case (state)
				IDLE: if (start) state <= FETCH;
				FETCH: begin
					if (ifu_req_valid && ifu_req_ready)
						ifu_wait <= 1'b1;
					if (ifu_rsp_valid) begin
						ifu_wait <= 1'b0;
						state    <= ifu_rsp.err ? HALT : EXEC;
						fault    <= ifu_rsp.err;
					end
				end
				EXEC: begin
					if (opcode == OP_SYSTEM) begin // ebreak
						state  <= HALT;
						retire <= 1'b1;
					end else if (is_load || is_store) begin
						state <= MEM;
					end else begin
						pc     <= next_pc;
						retire <= 1'b1;
						state  <= FETCH;
					end
				end
				MEM: begin
					if (lsu_req_valid && lsu_req_ready)
						lsu_wait <= 1'b1;
					if (lsu_rsp_valid) begin
						lsu_wait <= 1'b0;
						if (lsu_rsp.err) begin
							state <= HALT;
							fault <= 1'b1;
						end else begin
							pc     <= pc_plus4;
							retire <= 1'b1;
							state  <= FETCH;
						end
					end
				end
				HALT: ;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode import soc_pkg::*; (
	input  wire word_t instr,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output reg_idx_t   rd,
	output word_t      imm,
	output logic [6:0] opcode,
	output logic [2:0] funct3,
	output logic       is_sub,
	output logic       wen_rd,
	output logic       is_load,
	output logic       is_store,
	output strb_t      mem_strb
);

	logic [6:0] op_raw;

	assign op_raw = instr[6:0];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];

	always_comb begin
		opcode = op_raw;
		imm    = {{20{instr[31]}}, instr[31:20]}; // I-type
		case (op_raw)
			OP_LUI:    imm = {instr[31:12], 12'b0};
			OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			OP_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			OP_IMM, OP_REG, OP_LOAD, OP_SYSTEM: ;
			default:   opcode = OP_SYSTEM; // Unknown opcode halts like ebreak
		endcase
	end

	assign is_sub   = (op_raw == OP_REG) && (funct3 == 3'b000) && instr[30];
	assign is_load  = (opcode == OP_LOAD);
	assign is_store = (opcode == OP_STORE);
	assign wen_rd   = (opcode == OP_LUI) || (opcode == OP_IMM) || (opcode == OP_REG)
		|| (opcode == OP_LOAD) || (opcode == OP_JAL);

	always_comb begin
		case (funct3[1:0])
			2'b00:   mem_strb = 4'b0001;
			2'b01:   mem_strb = 4'b0011;
			default: mem_strb = 4'b1111;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  strb_t;
	typedef logic [4:0]  reg_idx_t;

	localparam addr_t RESET_PC   = 32'h8000_0000;
	localparam addr_t SRAM_BASE  = 32'h8000_0000;
	localparam int    SRAM_WORDS = 256;
	localparam int    SRAM_AW    = $clog2(SRAM_WORDS);
	localparam addr_t UART_ADDR  = 32'h1000_0000;

	typedef logic [SRAM_AW-1:0] sram_idx_t; // Word index into SRAM

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		strb_t wstrb;
		logic  write;
	} bus_req_t;

	typedef struct packed {
		word_t rdata;
		logic  err;
	} bus_rsp_t;

	typedef struct packed {
		logic      en;
		sram_idx_t idx;
		word_t     data;
	} boot_wr_t;

	typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, HALT} core_state_t;

endpackage

`default_nettype wire

// ==== source/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
	input  wire           clock,
	input  wire           rst_n,
	input  wire           start,
	input  wire boot_wr_t boot,
	output addr_t         pc,
	output logic          retire,
	output logic          halted,
	output logic          fault,
	output word_t         halt_ret,
	output logic          tx_valid,
	output logic [7:0]    tx_data
);

	bus_req_t ifu_req, lsu_req, sram_req, uart_req;
	bus_rsp_t ifu_rsp, lsu_rsp, sram_rsp, uart_rsp;
	logic     ifu_req_valid, ifu_req_ready, ifu_rsp_valid;
	logic     lsu_req_valid, lsu_req_ready, lsu_rsp_valid;
	logic     sram_req_valid, sram_req_ready, sram_rsp_valid;
	logic     uart_req_valid, uart_req_ready, uart_rsp_valid;

	rv_core u_core (
		.clock, .rst_n, .start,
		.ifu_req, .ifu_req_valid, .ifu_req_ready, .ifu_rsp, .ifu_rsp_valid,
		.lsu_req, .lsu_req_valid, .lsu_req_ready, .lsu_rsp, .lsu_rsp_valid,
		.pc, .retire, .halted, .fault, .halt_ret
	);

	bus_xbar u_xbar (
		.clock, .rst_n,
		.ifu_req, .ifu_req_valid, .ifu_req_ready, .ifu_rsp, .ifu_rsp_valid,
		.lsu_req, .lsu_req_valid, .lsu_req_ready, .lsu_rsp, .lsu_rsp_valid,
		.sram_req, .sram_req_valid, .sram_req_ready, .sram_rsp, .sram_rsp_valid,
		.uart_req, .uart_req_valid, .uart_req_ready, .uart_rsp, .uart_rsp_valid
	);

	sram_slave u_sram (
		.clock, .rst_n, .boot,
		.req(sram_req), .req_valid(sram_req_valid), .req_ready(sram_req_ready),
		.rsp(sram_rsp), .rsp_valid(sram_rsp_valid)
	);

	uart_tx_slave u_uart (
		.clock, .rst_n,
		.req(uart_req), .req_valid(uart_req_valid), .req_ready(uart_req_ready),
		.rsp(uart_rsp), .rsp_valid(uart_rsp_valid),
		.tx_valid, .tx_data
	);

endmodule

`default_nettype wire

// ==== source/sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_slave import soc_pkg::*; (
	input  wire           clock,
	input  wire           rst_n,
	input  wire boot_wr_t boot,
	input  wire bus_req_t req,
	input  wire           req_valid,
	output logic          req_ready,
	output bus_rsp_t      rsp,
	output logic          rsp_valid
);

	word_t      mem [SRAM_WORDS];
	word_t      rdata_q;
	sram_idx_t  idx;
	logic [7:0] lfsr;
	logic [1:0] count;
	logic       busy;
	logic       accept;

	assign idx       = req.addr[SRAM_AW+1:2]; // Upper bits ignored
	assign req_ready = !busy;
	assign accept    = req_valid && req_ready;
	assign rsp_valid = busy && (count == 2'd0);
	assign rsp       = '{rdata: rdata_q, err: 1'b0};

	always_ff @(posedge clock) begin
		if (boot.en)
			mem[boot.idx] <= boot.data;
		if (accept) begin
			rdata_q <= mem[idx];
			if (req.write) begin
				for (int b = 0; b < 4; b++)
					if (req.wstrb[b])
						mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			lfsr  <= 8'ha5; // Nonzero seed
			count <= 2'd0;
			busy  <= 1'b0;
		end else if (accept) begin
			lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
			count <= lfsr[1:0];
			busy  <= 1'b1;
		end else if (busy) begin
			if (count == 2'd0)
				busy <= 1'b0;
			else
				count <= count - 2'd1;
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_tx_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_slave import soc_pkg::*; (
	input  wire           clock,
	input  wire           rst_n,
	input  wire bus_req_t req,
	input  wire           req_valid,
	output logic          req_ready,
	output bus_rsp_t      rsp,
	output logic          rsp_valid,
	output logic          tx_valid,
	output logic [7:0]    tx_data
);

	logic accept;

	assign req_ready = !rsp_valid;
	assign accept    = req_valid && req_ready;
	assign rsp       = '{rdata: '0, err: 1'b0}; // Write-only so reads give zero

	always_ff @(posedge clock) begin
		if (accept)
			tx_data <= req.wdata[7:0];
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			tx_valid  <= 1'b0;
		end else begin
			rsp_valid <= accept;
			tx_valid  <= accept && req.write && req.wstrb[0];
		end
	end

endmodule

`default_nettype wire
